// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "failure reported in $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run ended without a result in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import isa_pkg::*, cpu_pkg::*; (
	input  alu_op_t         op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] result,
	output logic            le
);

	// signed compare for blet
	assign le = ($signed(a) <= $signed(b));

	always_comb begin
		case (op)
			ALU_ADD:  result = a + b;
			ALU_PASS: result = b;                     // li takes the immediate
			ALU_LE:   result = {{(XLEN-1){1'b0}}, le};
			default:  result = a + b;
		endcase
	end

endmodule

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ns
`default_nettype none

module control_unit import isa_pkg::*, cpu_pkg::*; (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   run,
	input  logic [XLEN-1:0]        instr,
	output logic                   fetch_en,
	output logic [IMEM_ADDR_W-1:0] pc,
	output logic [REG_ADDR_W-1:0]  rs_addr,
	output logic [REG_ADDR_W-1:0]  rt_addr,
	input  logic [XLEN-1:0]        rs_data,
	input  logic [XLEN-1:0]        rt_data,
	output logic                   wr_en,
	output logic [REG_ADDR_W-1:0]  wr_addr,
	output logic [XLEN-1:0]        wr_data,
	output alu_op_t                alu_op,
	output logic [XLEN-1:0]        alu_a,
	output logic [XLEN-1:0]        alu_b,
	input  logic [XLEN-1:0]        alu_result,
	input  logic                   alu_le,
	output logic                   mem_we,
	output logic [DMEM_ADDR_W-1:0] mem_addr,
	input  logic [XLEN-1:0]        mem_rdata,
	output logic                   out_valid,
	output logic [OUT_PORT_W-1:0]  out_port,
	output logic [XLEN-1:0]        out_data,
	output logic                   halted,
	output logic                   illegal
);

	ctrl_state_t            state;
	logic [XLEN-1:0]        ir;                       // instruction register
	logic [XLEN-1:0]        result_q;                 // value for writeback
	opcode_t                op;
	logic [XLEN-1:0]        imm_sext;
	logic [JADDR_W-1:0]     target;
	logic                   redirect;                 // taken blet or j
	logic [IMEM_ADDR_W-1:0] pc_next;

	// decode fields
	assign op       = opcode_t'(ir[OPCODE_LSB +: OPCODE_W]);
	assign rs_addr  = ir[RS_LSB +: REG_ADDR_W];
	assign rt_addr  = ir[RT_LSB +: REG_ADDR_W];
	assign imm_sext = {{(XLEN-IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};

	// blet targets the immediate, j the low jump bits
	assign target   = (op == J) ? ir[JADDR_W-1:0] : {{(JADDR_W-IMM_W){1'b0}}, ir[IMM_W-1:0]};
	assign redirect = (op == J) || ((op == BLET) && alu_le);
	assign pc_next  = redirect ? target[IMEM_ADDR_W-1:0] : pc + 1'b1;

	always_comb begin
		case (op)
			ADDI:    alu_op = ALU_ADD;
			LI:      alu_op = ALU_PASS;
			BLET:    alu_op = ALU_LE;
			default: alu_op = ALU_ADD;
		endcase
	end

	assign alu_a = rs_data;
	assign alu_b = (op == BLET) ? rt_data : imm_sext;

	assign fetch_en = (state == FETCH);
	assign wr_en    = (state == WRITEBACK);
	assign wr_addr  = rt_addr;                        // li, addi and lw all write rt
	assign wr_data  = result_q;
	assign mem_we   = (state == MEMORY) && (op == SW);
	assign mem_addr = rs_data[DMEM_ADDR_W-1:0];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			pc        <= '0;
			out_valid <= 1'b0;
			halted    <= 1'b0;
			illegal   <= 1'b0;
		end else begin
			out_valid <= 1'b0;                        // single cycle strobe
			if (!run) begin
				state   <= IDLE;
				pc      <= '0;
				halted  <= 1'b0;
				illegal <= 1'b0;
			end else begin
				case (state)
					IDLE:    state <= FETCH;
					FETCH:   state <= DECODE;
					DECODE:  state <= EXECUTE;
					EXECUTE: begin
						pc <= pc_next;
						case (op)
							LI, ADDI: state <= WRITEBACK;
							LW, SW:   state <= MEMORY;
							BLET, J:  state <= FETCH;
							OUT: begin
								out_valid <= 1'b1;
								state     <= FETCH;
							end
							HALT: begin
								halted <= 1'b1;
								state  <= HALTED;
							end
							default: begin            // unknown opcode stops the core
								halted  <= 1'b1;
								illegal <= 1'b1;
								state   <= HALTED;
							end
						endcase
					end
					MEMORY:    state <= (op == LW) ? WRITEBACK : FETCH;
					WRITEBACK: state <= FETCH;
					HALTED:    state <= HALTED;           // wait for run to drop
					default:   state <= IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == DECODE) begin
			ir <= instr;
		end
		if (state == EXECUTE) begin
			result_q <= alu_result;
			if (op == OUT) begin
				out_port <= ir[OUT_PORT_W-1:0];       // port from imm bits 3:0
				out_data <= rt_data;
			end
		end
		if ((state == MEMORY) && (op == LW)) begin
			result_q <= mem_rdata;
		end
	end

	// a taken blet or j must land inside the program store
	a_target_in_range: assert property (@(posedge clock) disable iff (!rst_n)
		((state == EXECUTE) && redirect) |-> (target < IMEM_DEPTH))
		else $error("branch or jump target %0d beyond program store", target);

	a_sw_addr_in_range: assert property (@(posedge clock) disable iff (!rst_n)
		((state == MEMORY) && (op == SW)) |-> (rs_data[XLEN-1:DMEM_ADDR_W] == '0))
		else $error("sw address 0x%08h beyond data store", rs_data);

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// register file and data store sizes
	localparam int NUM_REGS    = 32;
	localparam int DMEM_DEPTH  = 32;                  // words
	localparam int DMEM_ADDR_W = 5;

	// width of the out port number
	localparam int OUT_PORT_W = 4;

	typedef enum logic [2:0] {
		IDLE,                                         // run low, pc held at 0
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,                                       // lw and sw only
		WRITEBACK,                                    // li, addi and lw only
		HALTED
	} ctrl_state_t;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_PASS,                                     // result is b
		ALU_LE                                        // signed a <= b
	} alu_op_t;

endpackage

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top import isa_pkg::*, cpu_pkg::*; (
	input  logic                   clock,
	input  logic                   rst_n,
	input  logic                   run,
	input  logic                   prog_we,
	input  logic [IMEM_ADDR_W-1:0] prog_addr,
	input  logic [XLEN-1:0]        prog_data,
	output logic                   out_valid,
	output logic [OUT_PORT_W-1:0]  out_port,
	output logic [XLEN-1:0]        out_data,
	output logic                   halted,
	output logic                   illegal
);

	logic                   fetch_en;
	logic [IMEM_ADDR_W-1:0] pc;
	logic [XLEN-1:0]        instr;
	logic [REG_ADDR_W-1:0]  rs_addr;
	logic [REG_ADDR_W-1:0]  rt_addr;
	logic [XLEN-1:0]        rs_data;
	logic [XLEN-1:0]        rt_data;
	logic                   wr_en;
	logic [REG_ADDR_W-1:0]  wr_addr;
	logic [XLEN-1:0]        wr_data;
	alu_op_t                alu_op;
	logic [XLEN-1:0]        alu_a;
	logic [XLEN-1:0]        alu_b;
	logic [XLEN-1:0]        alu_result;
	logic                   alu_le;
	logic                   mem_we;
	logic [DMEM_ADDR_W-1:0] mem_addr;
	logic [XLEN-1:0]        mem_rdata;

	control_unit ctrl0 (
		.clock, .rst_n, .run, .instr, .fetch_en, .pc,
		.rs_addr, .rt_addr, .rs_data, .rt_data,
		.wr_en, .wr_addr, .wr_data,
		.alu_op, .alu_a, .alu_b, .alu_result, .alu_le,
		.mem_we, .mem_addr, .mem_rdata,
		.out_valid, .out_port, .out_data, .halted, .illegal
	);

	instruction_memory imem0 (
		.clock, .prog_we, .prog_addr, .prog_data, .fetch_en, .pc, .instr
	);

	register_file regs0 (
		.clock, .rst_n, .rs_addr, .rt_addr, .rs_data, .rt_data,
		.wr_en, .wr_addr, .wr_data
	);

	alu alu0 (
		.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .le(alu_le)
	);

	// sw data comes straight from the rt read port
	data_memory dmem0 (
		.clock, .mem_we, .mem_addr, .mem_wdata(rt_data), .mem_rdata
	);

endmodule

`default_nettype wire

// File: data_memory.sv
`timescale 1ns/1ns
`default_nettype none

module data_memory import isa_pkg::*, cpu_pkg::*; (
	input  logic                   clock,
	input  logic                   mem_we,
	input  logic [DMEM_ADDR_W-1:0] mem_addr,
	input  logic [XLEN-1:0]        mem_wdata,
	output logic [XLEN-1:0]        mem_rdata
);

	logic [XLEN-1:0] mem [DMEM_DEPTH];

	always_ff @(posedge clock) begin
		if (mem_we) begin
			mem[mem_addr] <= mem_wdata;               // sw in the memory cycle
		end
	end

	// lw reads in the same cycle
	assign mem_rdata = mem[mem_addr];

endmodule

`default_nettype wire

// File: instruction_memory.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_memory import isa_pkg::*; (
	input  logic                   clock,
	input  logic                   prog_we,
	input  logic [IMEM_ADDR_W-1:0] prog_addr,
	input  logic [XLEN-1:0]        prog_data,
	input  logic                   fetch_en,
	input  logic [IMEM_ADDR_W-1:0] pc,
	output logic [XLEN-1:0]        instr
);

	logic [XLEN-1:0] mem [IMEM_DEPTH];

	// an all-zero word decodes as an illegal opcode
	initial begin
		for (int i = 0; i < IMEM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (prog_we) begin
			mem[prog_addr] <= prog_data;              // host load, one word per strobe
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_en) begin
			instr <= mem[pc];                         // ready in the decode cycle
		end
	end

	// the host only loads while the core is stopped
	a_no_load_during_fetch: assert property (@(posedge clock) !(prog_we && fetch_en))
		else $error("program load while the core is fetching");

	a_loaded_opcode_legal: assert property (@(posedge clock)
		prog_we |-> prog_data[OPCODE_LSB +: OPCODE_W] inside
			{ADDI, LW, LI, SW, BLET, J, OUT, HALT})
		else $error("loaded word at %0d has an unknown opcode", prog_addr);

endmodule

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

package isa_pkg;

	// word and field widths
	localparam int XLEN       = 32;
	localparam int OPCODE_W   = 6;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W      = 16;
	localparam int JADDR_W    = 26;

	// field positions inside an instruction word
	localparam int OPCODE_LSB = 26;                   // opcode in bits 31:26
	localparam int RS_LSB     = 21;                   // rs in bits 25:21
	localparam int RT_LSB     = 16;                   // rt in bits 20:16

	// program store
	localparam int IMEM_DEPTH  = 64;
	localparam int IMEM_ADDR_W = 6;

	typedef enum logic [OPCODE_W-1:0] {
		ADDI = 6'b000010,                             // rt = rs + sext(imm)
		LW   = 6'b010011,                             // rt = dmem[rs]
		LI   = 6'b010100,                             // rt = sext(imm)
		SW   = 6'b010110,                             // dmem[rs] = rt
		BLET = 6'b011010,                             // if rs <= rt goto imm
		J    = 6'b011101,                             // goto jump field
		OUT  = 6'b100001,                             // port imm[3:0] gets rt
		HALT = 6'b111111                              // stop the core
	} opcode_t;

endpackage

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file import isa_pkg::*, cpu_pkg::*; (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs_addr,
	input  logic [REG_ADDR_W-1:0] rt_addr,
	output logic [XLEN-1:0]       rs_data,
	output logic [XLEN-1:0]       rt_data,
	input  logic                  wr_en,
	input  logic [REG_ADDR_W-1:0] wr_addr,
	input  logic [XLEN-1:0]       wr_data
);

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;                 // r0 writes are dropped
		end
	end

	// both read ports are combinational
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	// r0 stays zero only because reset clears it and writes skip it
	a_r0_reads_zero: assert property (@(posedge clock) disable iff (!rst_n)
		(rs_addr == '0) |-> (rs_data == '0))
		else $error("register 0 read back a nonzero value");

endmodule

`default_nettype wire

// File: tb.f
isa_pkg.sv
cpu_pkg.sv
instruction_memory.sv
register_file.sv
alu.sv
data_memory.sv
control_unit.sv
cpu_top.sv
tb_cpu.sv

// File: tb_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpu import isa_pkg::*, cpu_pkg::*; ();

	localparam int CLK_PERIOD   = 10;
	localparam int NUM_ROWS     = 12;
	localparam int ROW_CYCLES   = 2000;
	localparam int WATCHDOG_NS  = NUM_ROWS * ROW_CYCLES * CLK_PERIOD;
	localparam int KIND_THRESH  = 0;                  // threshold program, ends in halt
	localparam int KIND_ILLEGAL = 1;                  // threshold program, jumps into empty words
	localparam int KIND_ADDI    = 2;                  // li, addi, out, halt
	localparam int R_X          = 1;
	localparam int R_ADDR       = 2;
	localparam int R_T          = 3;
	localparam int R_SUM        = 4;
	localparam int R_LOAD       = 11;
	localparam int DMEM_SLOT    = 5;
	localparam int ADDI_IMM     = -7;
	localparam int UNLOADED     = 63;                 // never written by any row

	typedef struct {
		int                 kind;
		logic signed [15:0] x;
		int                 exp_count;
		bit                 exp_illegal;
	} row_t;

	logic                   clock;
	logic                   rst_n;
	logic                   run;
	logic                   prog_we;
	logic [IMEM_ADDR_W-1:0] prog_addr;
	logic [XLEN-1:0]        prog_data;
	logic                   out_valid;
	logic [OUT_PORT_W-1:0]  out_port;
	logic [XLEN-1:0]        out_data;
	logic                   halted;
	logic                   illegal;

	row_t                  rows [NUM_ROWS];
	int                    thresholds [3] = '{12, 10, 11};
	logic [XLEN-1:0]       prog [$];
	logic [OUT_PORT_W-1:0] got_port [$];
	logic [XLEN-1:0]       got_data [$];
	logic [OUT_PORT_W-1:0] exp_port [$];
	logic [XLEN-1:0]       exp_data [$];
	integer                seed = 50715;
	int                    errors = 0;
	int                    checks = 0;

	cpu_top dut0 (
		.clock, .rst_n, .run, .prog_we, .prog_addr, .prog_data,
		.out_valid, .out_port, .out_data, .halted, .illegal
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD/2) clock = ~clock;
	end

	// outputs are settled by the falling edge
	always @(negedge clock) begin
		if (out_valid === 1'b1) begin
			got_port.push_back(out_port);
			got_data.push_back(out_data);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [XLEN-1:0] enc_imm(opcode_t op, int rs, int rt, logic [15:0] imm);
		logic [XLEN-1:0] w;
		w = '0;
		w[OPCODE_LSB +: OPCODE_W] = op;
		w[RS_LSB +: REG_ADDR_W]   = rs[REG_ADDR_W-1:0];
		w[RT_LSB +: REG_ADDR_W]   = rt[REG_ADDR_W-1:0];
		w[15:0]                   = imm;
		return w;
	endfunction

	function automatic logic [XLEN-1:0] enc_jump(int addr);
		logic [XLEN-1:0] w;
		w = '0;
		w[OPCODE_LSB +: OPCODE_W] = J;
		w[JADDR_W-1:0]            = addr[JADDR_W-1:0];
		return w;
	endfunction

	task automatic set_row(input int idx, input int kind, input logic [15:0] x, input int cnt,
		input bit ill);
		rows[idx].kind        = kind;
		rows[idx].x           = x;
		rows[idx].exp_count   = cnt;
		rows[idx].exp_illegal = ill;
	endtask

	task automatic fill_table();
		logic [31:0] rnd;
		set_row(0, KIND_THRESH, 16'd0, 3, 1'b0);
		set_row(1, KIND_THRESH, 16'd10, 3, 1'b0);
		set_row(2, KIND_THRESH, 16'd11, 3, 1'b0);
		set_row(3, KIND_THRESH, 16'd12, 3, 1'b0);
		set_row(4, KIND_THRESH, 16'd13, 3, 1'b0);
		set_row(5, KIND_THRESH, 16'hfffb, 3, 1'b0);      // -5
		for (int k = 6; k < 9; k++) begin
			rnd = $random(seed);
			set_row(k, KIND_THRESH, rnd[15:0], 3, 1'b0);
		end
		set_row(9, KIND_ILLEGAL, 16'd11, 3, 1'b1);
		set_row(10, KIND_ADDI, 16'd20, 1, 1'b0);
		set_row(11, KIND_ADDI, 16'hfffd, 1, 1'b0);       // -3
	endtask

	task automatic build_program(input row_t r);
		int base;
		prog.delete();
		prog.push_back(enc_imm(LI, 0, R_X, r.x));
		if (r.kind == KIND_ADDI) begin
			prog.push_back(enc_imm(ADDI, R_X, R_SUM, 16'(ADDI_IMM)));
			prog.push_back(enc_imm(OUT, 0, R_SUM, 16'd2));
			prog.push_back(enc_imm(HALT, 0, 0, 16'd0));
		end else begin
			// round trip x through data memory into r11
			prog.push_back(enc_imm(LI, 0, R_ADDR, 16'(DMEM_SLOT)));
			prog.push_back(enc_imm(SW, R_ADDR, R_X, 16'd0));
			prog.push_back(enc_imm(LW, R_ADDR, R_LOAD, 16'd0));
			foreach (thresholds[i]) begin
				base = prog.size();
				prog.push_back(enc_imm(LI, 0, R_T, 16'(thresholds[i])));
				prog.push_back(enc_imm(BLET, R_LOAD, R_T, 16'(base + 4)));
				prog.push_back(enc_imm(OUT, 0, R_T, 16'd0));
				prog.push_back(enc_jump(base + 5));
				prog.push_back(enc_imm(OUT, 0, R_T, 16'd1));   // taken path
			end
			if (r.kind == KIND_ILLEGAL) begin
				prog.push_back(enc_jump(UNLOADED));
			end else begin
				prog.push_back(enc_imm(HALT, 0, 0, 16'd0));
			end
		end
	endtask

	// reference model straight from the ISA rules
	task automatic expect_events(input row_t r);
		exp_port.delete();
		exp_data.delete();
		if (r.kind == KIND_ADDI) begin
			exp_port.push_back(4'd2);
			exp_data.push_back(32'(int'(r.x) + ADDI_IMM));
		end else begin
			foreach (thresholds[i]) begin
				exp_port.push_back((int'(r.x) <= thresholds[i]) ? 4'd1 : 4'd0);
				exp_data.push_back(32'(thresholds[i]));
			end
		end
	endtask

	task automatic load_program();
		foreach (prog[i]) begin
			@(negedge clock);
			prog_we   = 1'b1;
			prog_addr = IMEM_ADDR_W'(i);
			prog_data = prog[i];
		end
		@(negedge clock);
		prog_we = 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp, input string ctx);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error: %s = 0x%0h, expected 0x%0h (%s)", name, got, exp, ctx);
		end
	endtask

	task automatic check_idle(input string ctx);
		check_value("out_valid", 32'(out_valid), 32'd0, ctx);
		check_value("halted", 32'(halted), 32'd0, ctx);
		check_value("illegal", 32'(illegal), 32'd0, ctx);
	endtask

	task automatic wait_halted(input int row);
		int n;
		n = 0;
		while ((halted !== 1'b1) && (n < ROW_CYCLES)) begin
			@(negedge clock);
			n++;
		end
		checks++;
		assert (halted === 1'b1) else begin
			errors++;
			$display("row %0d: the core did not halt within %0d cycles", row, ROW_CYCLES);
		end
	endtask

	task automatic compare_events(input int row, input row_t r);
		int n;
		string ctx;
		ctx = $sformatf("row %0d, x %0d", row, r.x);
		check_value("out event count", 32'(got_port.size()), 32'(r.exp_count), ctx);
		check_value("illegal", 32'(illegal), 32'(r.exp_illegal), ctx);
		n = (got_port.size() < exp_port.size()) ? got_port.size() : exp_port.size();
		for (int k = 0; k < n; k++) begin
			check_value("out_port", 32'(got_port[k]), 32'(exp_port[k]),
				$sformatf("%s, event %0d", ctx, k));
			check_value("out_data", got_data[k], exp_data[k],
				$sformatf("%s, event %0d", ctx, k));
		end
	endtask

	initial begin
		row_t r;
		rst_n     = 1'b0;
		run       = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		fill_table();
		repeat (3) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		check_idle("after reset");
		for (int i = 0; i < NUM_ROWS; i++) begin
			r = rows[i];
			build_program(r);
			expect_events(r);
			load_program();
			check_idle($sformatf("row %0d loaded, run low", i));
			got_port.delete();
			got_data.delete();
			run = 1'b1;
			wait_halted(i);
			check_value("illegal", 32'(illegal), 32'(r.exp_illegal),
				$sformatf("row %0d, at halt", i));
			repeat (8) @(negedge clock);              // catch any late strobe
			compare_events(i, r);
			run = 1'b0;
			repeat (2) @(negedge clock);
			check_idle($sformatf("row %0d, run dropped", i));
		end
		$display("tb_cpu: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
